/* dv/cw_bridge_assert.sv */
`timescale 1ns/100ps
`include "cw_settings.svh"

module cw_bridge_assert (
    input logic                     i_clk,
    input logic                     i_rst,
    input logic                     req_i,
    input logic                     dir_i,
    input logic                     ack_i,
    input logic                     err_i,
    input logic                     cyc_i,
    input logic                     stb_i,
    input logic [`CW_WB_ADDR_W-1:0] adr_i
);

    localparam logic [`CW_WB_ADDR_W-1:0] IGNORE_LIMIT = `CW_IGNORE_LIMIT;

    int unsigned fail_cnt = 0;

    req_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
        req_i |=> !req_i)
        else begin
            $error("link req stayed high for more than one cycle");
            fail_cnt++;
        end

    ack_err_apart: assert property (@(posedge i_clk) disable iff (i_rst)
        !(ack_i && err_i))
        else begin
            $error("wb_ack_o and wb_err_o are high together");
            fail_cnt++;
        end

    // the link turns around only between requests
    dir_not_req: assert property (@(posedge i_clk) disable iff (i_rst)
        !(dir_i && req_i))
        else begin
            $error("link dir is high while req is high");
            fail_cnt++;
        end

    ignored_no_req: assert property (@(posedge i_clk) disable iff (i_rst)
        (cyc_i && stb_i && (adr_i < IGNORE_LIMIT)) |=> !req_i)
        else begin
            $error("a link req followed an address in the ignored region");
            fail_cnt++;
        end

endmodule

bind wb_compressor cw_bridge_assert assert_i (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .req_i     (link.req),
    .dir_i     (link.dir),
    .ack_i     (wb_ack_o),
    .err_i     (wb_err_o),
    .cyc_i     (wb_cyc_i),
    .stb_i     (wb_stb_i),
    .adr_i     (wb_adr_i)
);

/* dv/cw_bridge_checker.sv */
`timescale 1ns/100ps
`include "cw_settings.svh"

module cw_bridge_checker (
    input logic                     i_clk,
    input logic                     i_rst,
    input logic                     cyc_i,
    input logic                     we_i,
    input logic [`CW_WB_ADDR_W-1:0] adr_i,
    input logic [`CW_RW-1:0]        wdat_i,
    input logic [1:0]               sel_i,
    input logic                     burst4_i,
    input logic                     burst8_i,
    input logic [`CW_RW-1:0]        rdat_i,
    input logic                     ack_i,
    input logic                     err_i
);

    localparam logic [`CW_WB_ADDR_W-1:0] WIN_BASE = `CW_IGNORE_LIMIT;
    localparam logic [`CW_WB_ADDR_W-1:0] WIN_TOP  = WIN_BASE + (1 << `CW_MEM_DEPTH_LOG);

    logic [`CW_RW-1:0]            model [0:(1<<`CW_MEM_DEPTH_LOG)-1];
    logic [`CW_WB_ADDR_W-1:0]     adr;
    logic [`CW_MEM_DEPTH_LOG-1:0] idx;
    logic                         exp_err;
    string                        test_name = "reset";
    int                           beat = 0;
    int                           n_beats;
    int                           n_ack = 0;
    int                           n_err = 0;
    int                           n_bad = 0;
    int                           total_beats = 0;
    int                           errors = 0;

    task automatic start_test(input string name);
        test_name = name;
        n_ack     = 0;
        n_err     = 0;
        n_bad     = 0;
    endtask

    task automatic end_test();
        $display("test %s finished, %0d acks, %0d errs, %0d errors",
                 test_name, n_ack, n_err, n_bad);
    endtask

    task automatic note_error(input string msg);
        $display("%s", msg);
        n_bad++;
        errors++;
    endtask

    // every ack or err closes one beat, judged mid cycle when the bus is settled
    always @(negedge i_clk) begin
        if (i_rst || !cyc_i) begin
            if (!i_rst && (ack_i || err_i)) begin
                note_error($sformatf("test %s: a response came with no cycle open", test_name));
            end
            beat = 0;
        end else if (ack_i || err_i) begin
            adr     = adr_i + `CW_WB_ADDR_W'(beat);  // beats walk up from the base address
            idx     = `CW_MEM_DEPTH_LOG'(adr - WIN_BASE);
            exp_err = (adr_i < WIN_BASE) || (adr >= WIN_TOP);
            n_beats = (adr_i < WIN_BASE) ? 1 : burst8_i ? 8 : burst4_i ? 4 : 1;
            if (beat >= n_beats) begin
                note_error($sformatf("Fail %s: expected %0d beats, actual %0d",
                                     test_name, n_beats, beat + 1));
            end else if (ack_i && exp_err) begin
                note_error($sformatf("test %s: wb_ack_o came where wb_err_o was expected at %h",
                                     test_name, adr));
            end else if (err_i && !exp_err) begin
                note_error($sformatf("test %s: wb_err_o came where wb_ack_o was expected at %h",
                                     test_name, adr));
            end else if (ack_i && we_i) begin
                for (int b = 0; b < `CW_RW/8; b++) begin
                    if (sel_i[b]) begin
                        model[idx][b*8 +: 8] = wdat_i[b*8 +: 8];
                    end
                end
            end else if (ack_i && rdat_i !== model[idx]) begin
                note_error($sformatf("Fail %s: expected %h, actual %h at address %h",
                                     test_name, model[idx], rdat_i, adr));
            end
            if (ack_i) begin
                n_ack++;
            end else begin
                n_err++;
            end
            beat++;
            total_beats++;
        end
    end

endmodule

/* dv/cw_bridge_tb.sv */
`timescale 1ns/100ps
`include "cw_settings.svh"

module cw_bridge_tb;

    localparam int N_RANDOM = 120;
    localparam int N_TXN    = 200;  // upper bound on wishbone cycles over all tests
    localparam logic [`CW_WB_ADDR_W-1:0] WIN_BASE = `CW_IGNORE_LIMIT;

    logic                     i_clk;
    logic                     i_rst;
    logic                     wb_cyc_i;
    logic                     wb_stb_i;
    logic                     wb_we_i;
    logic [`CW_WB_ADDR_W-1:0] wb_adr_i;
    logic [`CW_RW-1:0]        wb_dat_i;
    logic [1:0]               wb_sel_i;
    logic                     wb_burst4_i;
    logic                     wb_burst8_i;
    logic [`CW_RW-1:0]        wb_dat_o;
    logic                     wb_ack_o;
    logic                     wb_err_o;

    logic [31:0]              lcg_state = 32'd23405;
    logic [`CW_RW-1:0]        wr_buf [0:7];
    int                       n_tests = 0;
    int                       n_cycles = 0;
    int                       n_fail;

    cw_bridge_top dut_i (.*);

    cw_bridge_checker chk_i (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .cyc_i    (wb_cyc_i),
        .we_i     (wb_we_i),
        .adr_i    (wb_adr_i),
        .wdat_i   (wb_dat_i),
        .sel_i    (wb_sel_i),
        .burst4_i (wb_burst4_i),
        .burst8_i (wb_burst8_i),
        .rdat_i   (wb_dat_o),
        .ack_i    (wb_ack_o),
        .err_i    (wb_err_o)
    );

    initial i_clk = 1'b0;
    always #10 i_clk = ~i_clk;

    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];  // upper bits have the longer period
    endfunction

    function automatic logic [15:0] fill_word(input logic [`CW_WB_ADDR_W-1:0] adr);
        return adr[15:0] ^ {adr[23:16], 8'hc3};
    endfunction

    task automatic begin_test(input string name);
        chk_i.start_test(name);
        n_tests++;
    endtask

    task automatic close_test();
        repeat (2) @(posedge i_clk);
        chk_i.end_test();
    endtask

    // runs one wishbone cycle of len beats with write data taken from wr_buf
    task automatic wb_cycle(input logic we, input logic [`CW_WB_ADDR_W-1:0] adr,
                            input int len, input logic [1:0] sel);
        int beat;
        int n_resp;
        beat   = 0;
        n_resp = (adr < WIN_BASE) ? 1 : len;  // the low region is refused with a single err
        @(posedge i_clk);
        wb_cyc_i    <= 1'b1;
        wb_stb_i    <= 1'b1;
        wb_we_i     <= we;
        wb_adr_i    <= adr;
        wb_sel_i    <= sel;
        wb_dat_i    <= wr_buf[0];
        wb_burst4_i <= (len == 4);
        wb_burst8_i <= (len == 8);
        while (beat < n_resp) begin
            @(negedge i_clk);
            if (wb_ack_o || wb_err_o) begin
                beat++;
                @(posedge i_clk);
                if (beat == n_resp) begin
                    wb_cyc_i <= 1'b0;
                    wb_stb_i <= 1'b0;
                end else if (we) begin
                    wb_stb_i <= 1'b0;  // write beats are strobed one at a time
                    wb_dat_i <= wr_buf[beat];
                    @(posedge i_clk);
                    wb_stb_i <= 1'b1;
                end
            end
        end
        n_cycles++;
    endtask

    task automatic fill_memory();
        begin_test("fill");
        for (int a = 0; a < (1 << `CW_MEM_DEPTH_LOG); a += 8) begin
            for (int k = 0; k < 8; k++) begin
                wr_buf[k] = fill_word(WIN_BASE + `CW_WB_ADDR_W'(a + k));
            end
            wb_cycle(1'b1, WIN_BASE + `CW_WB_ADDR_W'(a), 8, 2'b11);
        end
        close_test();
    endtask

    task automatic single_beats();
        logic [`CW_WB_ADDR_W-1:0] adr;
        logic [15:0]              r;
        begin_test("single");
        for (int i = 0; i < 8; i++) begin
            r         = rand16();
            adr       = WIN_BASE + `CW_WB_ADDR_W'(r[7:0]);
            wr_buf[0] = rand16();
            wb_cycle(1'b1, adr, 1, r[9:8]);  // sel may mask one lane or both
            wb_cycle(1'b0, adr, 1, 2'b11);
        end
        close_test();
    endtask

    task automatic bursts();
        logic [`CW_WB_ADDR_W-1:0] adr;
        begin_test("burst");
        for (int len = 4; len <= 8; len += 4) begin
            adr = WIN_BASE + `CW_WB_ADDR_W'(rand16() & 16'h00f0);
            for (int k = 0; k < 8; k++) begin
                wr_buf[k] = rand16();
            end
            wb_cycle(1'b1, adr, len, 2'b11);
            wb_cycle(1'b0, adr, len, 2'b11);
        end
        close_test();
    endtask

    task automatic ignored_region();
        logic [`CW_WB_ADDR_W-1:0] adr;
        begin_test("ignored");
        adr = 24'h001000 | `CW_WB_ADDR_W'(rand16() & 16'h0fff);
        for (int k = 0; k < 8; k++) begin
            wr_buf[k] = rand16();
        end
        wb_cycle(1'b1, adr, 1, 2'b11);
        wb_cycle(1'b1, adr, 8, 2'b11);
        wb_cycle(1'b0, adr, 1, 2'b11);
        wb_cycle(1'b0, WIN_BASE + `CW_WB_ADDR_W'(adr[7:0]), 1, 2'b11);
        close_test();
    endtask

    task automatic window_edge();
        logic [`CW_WB_ADDR_W-1:0] adr;
        begin_test("edge");
        adr = WIN_BASE + `CW_WB_ADDR_W'((1 << `CW_MEM_DEPTH_LOG) - 4);
        for (int k = 0; k < 8; k++) begin
            wr_buf[k] = rand16();
        end
        wb_cycle(1'b1, adr, 8, 2'b11);
        wb_cycle(1'b0, adr, 8, 2'b11);
        wb_cycle(1'b0, WIN_BASE, 8, 2'b11);  // dropped beats would alias onto the window base
        close_test();
    endtask

    task automatic random_mix();
        logic [`CW_WB_ADDR_W-1:0] adr;
        logic [15:0]              r;
        int                       len;
        begin_test("random");
        for (int i = 0; i < N_RANDOM; i++) begin
            r   = rand16();
            adr = WIN_BASE - 24'h10 + `CW_WB_ADDR_W'(rand16() % 16'h0120);
            len = (r[1:0] == 2'd0) ? 8 : (r[1:0] == 2'd1) ? 4 : 1;
            for (int k = 0; k < 8; k++) begin
                wr_buf[k] = rand16();
            end
            wb_cycle(r[2], adr, len, r[4:3]);
        end
        close_test();
    endtask

    initial begin
        i_rst       = 1'b1;
        wb_cyc_i    = 1'b0;
        wb_stb_i    = 1'b0;
        wb_we_i     = 1'b0;
        wb_adr_i    = '0;
        wb_dat_i    = '0;
        wb_sel_i    = 2'b00;
        wb_burst4_i = 1'b0;
        wb_burst8_i = 1'b0;
        repeat (3) @(posedge i_clk);
        i_rst <= 1'b0;
        repeat (5) @(posedge i_clk);  // the checker flags any stray response on the quiet bus
        fill_memory();
        single_beats();
        bursts();
        ignored_region();
        window_edge();
        random_mix();
        repeat (4) @(posedge i_clk);
        n_fail = chk_i.errors + int'(dut_i.comp_i.assert_i.fail_cnt);
        $display("tests %0d, cycles %0d, beats %0d, errors %0d",
                 n_tests, n_cycles, chk_i.total_beats, n_fail);
        if (n_fail == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(N_TXN * 8 * 20 * 20);
        $display("timeout: the bridge stopped answering before all tests were done");
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* include/cw_settings.svh */
`ifndef CW_SETTINGS_SVH
`define CW_SETTINGS_SVH

// link word and wishbone data width
`define CW_RW 16

// wishbone word address width whose top byte travels in the header word
`define CW_WB_ADDR_W 24

// beat counter width, enough for an 8-beat burst
`define CW_MAX_BRST_LOG 3

// log2 of the target memory depth in words
`define CW_MEM_DEPTH_LOG 8

// addresses below this are never forwarded over the link
`define CW_IGNORE_LIMIT 'h002000

`endif

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module cw_bridge_tb -f vlog.f -o cw_bridge_sim

status=0
./obj_dir/cw_bridge_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Result: PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi

/* verilog/cw_bridge_top.sv */
`timescale 1ns/100ps
`include "cw_settings.svh"

module cw_bridge_top (
    input  logic                     i_clk,
    input  logic                     i_rst,

    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  logic [`CW_WB_ADDR_W-1:0] wb_adr_i,
    input  logic [`CW_RW-1:0]        wb_dat_i,
    input  logic [1:0]               wb_sel_i,
    input  logic                     wb_burst4_i,
    input  logic                     wb_burst8_i,
    output logic [`CW_RW-1:0]        wb_dat_o,
    output logic                     wb_ack_o,
    output logic                     wb_err_o
);

    logic                     mem_we;
    logic [`CW_WB_ADDR_W-1:0] mem_adr;
    logic [`CW_RW-1:0]        mem_wdat;
    logic [`CW_RW-1:0]        mem_rdat;
    logic [1:0]               mem_sel;
    logic                     mem_err;

    cw_link_if link_i ();

    wb_compressor comp_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_sel_i    (wb_sel_i),
        .wb_burst4_i (wb_burst4_i),
        .wb_burst8_i (wb_burst8_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .wb_err_o    (wb_err_o),
        .link        (link_i)
    );

    cw_decompressor decomp_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .link      (link_i),
        .mem_we_o  (mem_we),
        .mem_adr_o (mem_adr),
        .mem_dat_o (mem_wdat),
        .mem_sel_o (mem_sel),
        .mem_dat_i (mem_rdat),
        .mem_err_i (mem_err)
    );

    cw_target_mem mem_i (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .we_i  (mem_we),
        .adr_i (mem_adr),
        .dat_i (mem_wdat),
        .sel_i (mem_sel),
        .dat_o (mem_rdat),
        .err_o (mem_err)
    );

endmodule

/* verilog/cw_decompressor.sv */
`timescale 1ns/100ps
`include "cw_settings.svh"

module cw_decompressor (
    input  logic                     i_clk,
    input  logic                     i_rst,

    cw_link_if.decomp                link,

    output logic                     mem_we_o,
    output logic [`CW_WB_ADDR_W-1:0] mem_adr_o,
    output logic [`CW_RW-1:0]        mem_dat_o,
    output logic [1:0]               mem_sel_o,
    input  logic [`CW_RW-1:0]        mem_dat_i,
    input  logic                     mem_err_i
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADR,
        S_HACK,
        S_RD,
        S_WWAIT
    } state_e;

    state_e                      state;
    cw_pkg::cw_header_t          hdr_in;
    cw_pkg::cw_header_t          hdr_q;
    logic [`CW_WB_ADDR_W-1:0]    base_q;
    logic [`CW_MAX_BRST_LOG-1:0] cnt;
    logic [`CW_MAX_BRST_LOG-1:0] beat_last;
    logic                        hack_q;  // header ack
    logic                        pend_q;  // a beat went to memory last cycle
    logic                        issue;

    assign hdr_in    = cw_pkg::cw_header_t'(link.io_o);
    assign beat_last = cw_pkg::beat_last(hdr_q.cyc_type);

    // reads stream from the header ack on, writes wait for a req per beat after the first
    assign issue = (state == S_HACK) || (state == S_RD) || (state == S_WWAIT && link.req);

    assign mem_we_o  = issue && hdr_q.we;
    assign mem_adr_o = base_q + {{(`CW_WB_ADDR_W-`CW_MAX_BRST_LOG){1'b0}}, cnt};
    assign mem_dat_o = link.io_o;
    assign mem_sel_o = hdr_q.sel;

    // memory data and range flag both arrive the cycle after the beat was issued
    assign link.io_i = mem_dat_i;
    assign link.ack  = hack_q || (pend_q && !mem_err_i);
    assign link.err  = pend_q && mem_err_i;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state  <= S_IDLE;
            hack_q <= 1'b0;
            pend_q <= 1'b0;
            cnt    <= '0;
        end else begin
            hack_q <= 1'b0;
            pend_q <= issue;

            case (state)
                S_IDLE: begin
                    if (link.req && hdr_in.valid) begin
                        hdr_q <= hdr_in;
                        state <= S_ADR;
                    end
                end
                S_ADR: begin
                    base_q <= {hdr_q.adr_hi, link.io_o};
                    hack_q <= 1'b1;
                    cnt    <= '0;
                    state  <= S_HACK;
                end
                S_HACK, S_RD, S_WWAIT: begin
                    if (issue) begin
                        if (cnt == beat_last) begin
                            state <= S_IDLE;
                        end else begin
                            cnt   <= cnt + 1'b1;
                            state <= hdr_q.we ? S_WWAIT : S_RD;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

/* verilog/cw_link_if.sv */
`timescale 1ns/100ps
`include "cw_settings.svh"

interface cw_link_if;

    logic [`CW_RW-1:0] io_o;  // compressor to target
    logic              req;
    logic              dir;   // high while read data flows back
    logic [`CW_RW-1:0] io_i;  // target to compressor
    logic              ack;
    logic              err;

    modport comp (
        output io_o, req, dir,
        input  io_i, ack, err
    );

    modport decomp (
        input  io_o, req, dir,
        output io_i, ack, err
    );

endinterface

/* verilog/cw_pkg.sv */
`include "cw_settings.svh"

package cw_pkg;

    typedef enum logic [3:0] {
        CYC_SINGLE = 4'd0,
        CYC_BURST8 = 4'd1,
        CYC_BURST4 = 4'd2
    } cyc_type_e;

    // first word of every link transfer
    typedef struct packed {
        logic [`CW_WB_ADDR_W-`CW_RW-1:0] adr_hi;
        cyc_type_e                       cyc_type;
        logic                            we;
        logic [1:0]                      sel;
        logic                            valid;
    } cw_header_t;

    // index of the last beat for a cycle type
    function automatic logic [`CW_MAX_BRST_LOG-1:0] beat_last(cyc_type_e t);
        case (t)
            CYC_BURST8: beat_last = `CW_MAX_BRST_LOG'd7;
            CYC_BURST4: beat_last = `CW_MAX_BRST_LOG'd3;
            default:    beat_last = '0;
        endcase
    endfunction

endpackage

/* verilog/cw_target_mem.sv */
`timescale 1ns/100ps
`include "cw_settings.svh"

module cw_target_mem (
    input  logic                     i_clk,
    input  logic                     i_rst,

    input  logic                     we_i,
    input  logic [`CW_WB_ADDR_W-1:0] adr_i,
    input  logic [`CW_RW-1:0]        dat_i,
    input  logic [1:0]               sel_i,
    output logic [`CW_RW-1:0]        dat_o,
    output logic                     err_o
);

    localparam logic [`CW_WB_ADDR_W-1:0] WIN_BASE = `CW_IGNORE_LIMIT;
    localparam logic [`CW_WB_ADDR_W-1:0] WIN_TOP  = WIN_BASE + (1 << `CW_MEM_DEPTH_LOG);

    logic [`CW_RW-1:0]           mem [0:(1<<`CW_MEM_DEPTH_LOG)-1];
    logic [`CW_WB_ADDR_W-1:0]    offset;
    logic [`CW_MEM_DEPTH_LOG-1:0] idx;
    logic                        out_of_range;

    assign offset       = adr_i - WIN_BASE;
    assign idx          = offset[`CW_MEM_DEPTH_LOG-1:0];
    assign out_of_range = adr_i >= WIN_TOP;

    // range flag lines up with the read data
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            err_o <= 1'b0;
        end else begin
            err_o <= out_of_range;
        end
    end

    always_ff @(posedge i_clk) begin
        dat_o <= mem[idx];
        if (we_i && !out_of_range) begin
            for (int b = 0; b < `CW_RW/8; b++) begin
                if (sel_i[b]) begin
                    mem[idx][b*8 +: 8] <= dat_i[b*8 +: 8];  // one enable per byte lane
                end
            end
        end
    end

endmodule

/* verilog/wb_compressor.sv */
`timescale 1ns/100ps
`include "cw_settings.svh"

module wb_compressor (
    input  logic                     i_clk,
    input  logic                     i_rst,

    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  logic [`CW_WB_ADDR_W-1:0] wb_adr_i,
    input  logic [`CW_RW-1:0]        wb_dat_i,
    input  logic [1:0]               wb_sel_i,
    input  logic                     wb_burst4_i,
    input  logic                     wb_burst8_i,
    output logic [`CW_RW-1:0]        wb_dat_o,
    output logic                     wb_ack_o,
    output logic                     wb_err_o,

    cw_link_if.comp                  link
);

    localparam logic [`CW_WB_ADDR_W-1:0] IGNORE_LIMIT = `CW_IGNORE_LIMIT;

    typedef enum logic [2:0] {
        S_IDLE,
        S_HDR,
        S_WACK,
        S_RDATA,
        S_WDATA,
        S_WWAIT,
        S_CLOSE
    } state_e;

    state_e                      state;
    cw_pkg::cyc_type_e           cyc_type;
    cw_pkg::cw_header_t          hdr;
    logic                        ignored;
    logic                        l_we;
    logic [`CW_MAX_BRST_LOG-1:0] burst_end;
    logic [`CW_MAX_BRST_LOG-1:0] cnt;
    logic                        beat_done;
    logic                        last_beat;

    always_comb begin
        if (wb_burst8_i) begin
            cyc_type = cw_pkg::CYC_BURST8;
        end else if (wb_burst4_i) begin
            cyc_type = cw_pkg::CYC_BURST4;
        end else begin
            cyc_type = cw_pkg::CYC_SINGLE;
        end
    end

    always_comb begin
        hdr.adr_hi   = wb_adr_i[`CW_WB_ADDR_W-1:`CW_RW];
        hdr.cyc_type = cyc_type;
        hdr.we       = wb_we_i;
        hdr.sel      = wb_sel_i;
        hdr.valid    = 1'b1;
    end

    // the low region is not mapped on the far side, so it is refused here
    assign ignored   = wb_adr_i < IGNORE_LIMIT;
    assign beat_done = link.ack || link.err;
    assign last_beat = cnt == burst_end;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= S_IDLE;
            link.req <= 1'b0;
            link.dir <= 1'b0;
            wb_ack_o <= 1'b0;
            wb_err_o <= 1'b0;
            cnt      <= '0;
        end else begin
            wb_ack_o <= 1'b0;  // wishbone strobes are single cycle
            wb_err_o <= 1'b0;
            link.req <= 1'b0;

            case (state)
                S_IDLE: begin
                    if (wb_cyc_i && wb_stb_i) begin
                        if (ignored) begin
                            wb_err_o <= 1'b1;
                            state    <= S_CLOSE;
                        end else begin
                            link.req  <= 1'b1;
                            link.io_o <= hdr;
                            l_we      <= wb_we_i;
                            burst_end <= cw_pkg::beat_last(cyc_type);
                            cnt       <= '0;
                            state     <= S_HDR;
                        end
                    end
                end
                S_HDR: begin
                    link.io_o <= wb_adr_i[`CW_RW-1:0];
                    state     <= S_WACK;
                end
                S_WACK: begin
                    // first write word sits on the link by the time the header is acked
                    link.io_o <= wb_dat_i;
                    if (link.ack) begin
                        link.dir <= ~l_we;
                        state    <= l_we ? S_WDATA : S_RDATA;
                    end
                end
                S_RDATA: begin
                    if (beat_done) begin
                        wb_ack_o <= link.ack;
                        wb_err_o <= link.err;
                        wb_dat_o <= link.io_i;
                        if (last_beat) begin
                            link.dir <= 1'b0;
                            state    <= S_CLOSE;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                S_WDATA: begin
                    if (beat_done) begin
                        wb_ack_o <= link.ack;
                        wb_err_o <= link.err;
                        if (last_beat) begin
                            state <= S_CLOSE;
                        end else begin
                            cnt   <= cnt + 1'b1;
                            state <= S_WWAIT;
                        end
                    end
                end
                S_WWAIT: begin
                    // the strobe still high under our own ack belongs to the old beat
                    if (wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o) begin
                        link.req  <= 1'b1;
                        link.io_o <= wb_dat_i;
                        state     <= S_WDATA;
                    end
                end
                S_CLOSE: begin
                    state <= S_IDLE;  // lets the master drop stb before idle samples it
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

/* vlog.f */
+incdir+include
verilog/cw_pkg.sv
verilog/cw_link_if.sv
verilog/wb_compressor.sv
verilog/cw_decompressor.sv
verilog/cw_target_mem.sv
verilog/cw_bridge_top.sv
dv/cw_bridge_assert.sv
dv/cw_bridge_checker.sv
dv/cw_bridge_tb.sv
